// ==== src/mulPkg.sv ====
`default_nettype none

package mulPkg;

    // ************************************************************************
    // Widths and depths of the multiply cluster
    // ************************************************************************

    localparam int XLEN     = 32;
    localparam int TAG_W    = 7;                  // Physical destination tag.
    localparam int REG_W    = 5;                  // Architectural register number.
    localparam int SQN_W    = 7;                  // Sequence numbers wrap at this width.

    localparam int IQ_DEPTH = 4;                  // Also the upstream credits after reset.
    localparam int RB_DEPTH = 4;
    localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
    localparam int RB_PTR_W = $clog2(RB_DEPTH);

    localparam int CREDIT_W = 3;
    localparam int CNT_W    = 3;                  // Holds any count from 0 to a full queue.

    // Partial-product steps of the multiplier in the cluster. The counter width
    // leaves room for up to 15 steps.
    localparam int MUL_STAGES  = 4;
    localparam int MUL_STAGE_W = 4;

    // ************************************************************************
    // Opcodes
    // ************************************************************************

    typedef enum logic [1:0] {
        MUL_MUL   = 2'd0,                         // Low half, any signedness.
        MUL_MULH  = 2'd1,                         // High half, signed by signed.
        MUL_MULSU = 2'd2,                         // High half, signed by unsigned.
        MUL_MULU  = 2'd3                          // High half, unsigned by unsigned.
    } MulOp;

    // ************************************************************************
    // Sequence age
    // ************************************************************************

    // True when a was dispatched after b, taking wrap-around into account.
    function automatic logic isYounger(input logic [SQN_W-1:0] a,
                                       input logic [SQN_W-1:0] b);
        logic [SQN_W-1:0] diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

`default_nettype wire

// ==== src/mulIssueQueue.sv ====
`timescale 1ns/1ns
`default_nettype none

module mulIssueQueue (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         inValid,
    input  wire mulPkg::MulOp           inOp,
    input  wire [mulPkg::XLEN-1:0]      inSrcA,
    input  wire [mulPkg::XLEN-1:0]      inSrcB,
    input  wire [mulPkg::TAG_W-1:0]     inTagDst,
    input  wire [mulPkg::REG_W-1:0]     inNmDst,
    input  wire [mulPkg::SQN_W-1:0]     inSqN,
    input  wire [mulPkg::XLEN-1:0]      inPc,
    input  wire                         busy,
    input  wire                         canReserve,
    input  wire                         branchTaken,
    input  wire [mulPkg::SQN_W-1:0]     branchSqN,
    output logic [mulPkg::CREDIT_W-1:0] creditReturn,
    output logic                        issueValid,
    output mulPkg::MulOp                issueOp,
    output logic [mulPkg::XLEN-1:0]     issueSrcA,
    output logic [mulPkg::XLEN-1:0]     issueSrcB,
    output logic [mulPkg::TAG_W-1:0]    issueTagDst,
    output logic [mulPkg::REG_W-1:0]    issueNmDst,
    output logic [mulPkg::SQN_W-1:0]    issueSqN,
    output logic [mulPkg::XLEN-1:0]     issuePc
);
    import mulPkg::*;

    MulOp                opQ    [IQ_DEPTH];
    logic [XLEN-1:0]     srcAQ  [IQ_DEPTH];
    logic [XLEN-1:0]     srcBQ  [IQ_DEPTH];
    logic [TAG_W-1:0]    tagQ   [IQ_DEPTH];
    logic [REG_W-1:0]    nmQ    [IQ_DEPTH];
    logic [SQN_W-1:0]    sqNQ   [IQ_DEPTH];
    logic [XLEN-1:0]     pcQ    [IQ_DEPTH];
    logic [IQ_DEPTH-1:0] validQ;
    logic [IQ_PTR_W-1:0] head;
    logic [IQ_PTR_W-1:0] tail;

    logic [IQ_DEPTH-1:0] kill;
    logic [CNT_W-1:0]    killCount;
    logic                inKilled;
    logic                accept;

    assign issueValid  = validQ[head] && !busy && canReserve;
    assign issueOp     = opQ[head];
    assign issueSrcA   = srcAQ[head];
    assign issueSrcB   = srcBQ[head];
    assign issueTagDst = tagQ[head];
    assign issueNmDst  = nmQ[head];
    assign issueSqN    = sqNQ[head];
    assign issuePc     = pcQ[head];

    assign inKilled = inValid && branchTaken && isYounger(inSqN, branchSqN);
    assign accept   = inValid && !inKilled;

    // A head that issues while being flushed is dropped downstream, so it is
    // counted once here as a pop and not again as a kill.
    always_comb begin
        killCount = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            kill[i] = validQ[i] && branchTaken && isYounger(sqNQ[i], branchSqN)
                      && !(issueValid && IQ_PTR_W'(i) == head);
            killCount = killCount + CNT_W'(kill[i]);
        end
    end

    assign creditReturn = CREDIT_W'(killCount) + CREDIT_W'(issueValid) + CREDIT_W'(inKilled);

    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= '0;
            head   <= '0;
            tail   <= '0;
        end else begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (kill[i])
                    validQ[i] <= 1'b0;
            end
            if (issueValid) begin
                validQ[head] <= 1'b0;
                head         <= head + 1'b1;
            end
            if (accept)
                validQ[tail] <= 1'b1;
            tail <= tail - IQ_PTR_W'(killCount) + IQ_PTR_W'(accept); // Killed run is the tail.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opQ[tail]   <= inOp;
            srcAQ[tail] <= inSrcA;
            srcBQ[tail] <= inSrcB;
            tagQ[tail]  <= inTagDst;
            nmQ[tail]   <= inNmDst;
            sqNQ[tail]  <= inSqN;
            pcQ[tail]   <= inPc;
        end
    end

endmodule

`default_nettype wire

// ==== src/multiplySmall.sv ====
`timescale 1ns/1ns
`default_nettype none

module multiplySmall #(
    parameter int NUM_STAGES = 4
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      issueValid,
    input  wire mulPkg::MulOp        issueOp,
    input  wire [mulPkg::XLEN-1:0]   issueSrcA,
    input  wire [mulPkg::XLEN-1:0]   issueSrcB,
    input  wire [mulPkg::TAG_W-1:0]  issueTagDst,
    input  wire [mulPkg::REG_W-1:0]  issueNmDst,
    input  wire [mulPkg::SQN_W-1:0]  issueSqN,
    input  wire [mulPkg::XLEN-1:0]   issuePc,
    input  wire                      branchTaken,
    input  wire [mulPkg::SQN_W-1:0]  branchSqN,
    output logic                     busy,
    output logic                     doneValid,
    output logic [mulPkg::XLEN-1:0]  doneResult,
    output logic [mulPkg::TAG_W-1:0] doneTagDst,
    output logic [mulPkg::REG_W-1:0] doneNmDst,
    output logic [mulPkg::SQN_W-1:0] doneSqN,
    output logic [mulPkg::XLEN-1:0]  donePc
);
    import mulPkg::*;

    logic [XLEN-1:0]        srcA;
    logic [XLEN-1:0]        srcB;
    logic [2*XLEN-1:0]      acc;
    logic                   invert;                 // Product of magnitudes must be negated.
    logic                   high;                   // Upper half is the result.
    logic [TAG_W-1:0]       tagDst;
    logic [REG_W-1:0]       nmDst;
    logic [SQN_W-1:0]       sqN;
    logic [XLEN-1:0]        pc;
    logic                   valid;
    logic [MUL_STAGE_W-1:0] stage;

    logic                   killHeld;
    logic                   killIn;
    logic                   finish;
    logic [2*XLEN-1:0]      partial;

    assign killHeld = branchTaken && isYounger(sqN, branchSqN);
    assign killIn   = branchTaken && isYounger(issueSqN, branchSqN);
    assign finish   = valid && (stage == MUL_STAGE_W'(NUM_STAGES));
    assign busy     = valid && !finish;             // The next op may load while this one ends.

    // srcA times one slice of srcB, moved up to the weight of that slice.
    assign partial = ({{XLEN{1'b0}}, srcA} * srcB[stage*(XLEN/NUM_STAGES) +: XLEN/NUM_STAGES])
                     << (stage*(XLEN/NUM_STAGES));

    always_ff @(posedge clk) begin
        if (rst) begin
            valid     <= 1'b0;
            stage     <= '0;
            doneValid <= 1'b0;
        end else begin
            doneValid <= finish && !killHeld;
            if (issueValid && !killIn) begin
                valid <= 1'b1;
                stage <= '0;
            end else if (finish || killHeld) begin
                valid <= 1'b0;
            end else if (valid) begin
                stage <= stage + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid) begin
            acc    <= '0;
            tagDst <= issueTagDst;
            nmDst  <= issueNmDst;
            sqN    <= issueSqN;
            pc     <= issuePc;
            high   <= (issueOp != MUL_MUL);
            case (issueOp)
                MUL_MULH: begin
                    invert <= issueSrcA[XLEN-1] ^ issueSrcB[XLEN-1];
                    srcA   <= issueSrcA[XLEN-1] ? -issueSrcA : issueSrcA;
                    srcB   <= issueSrcB[XLEN-1] ? -issueSrcB : issueSrcB;
                end
                MUL_MULSU: begin
                    invert <= issueSrcA[XLEN-1];
                    srcA   <= issueSrcA[XLEN-1] ? -issueSrcA : issueSrcA;
                    srcB   <= issueSrcB;
                end
                default: begin                      // Low half needs no sign handling.
                    invert <= 1'b0;
                    srcA   <= issueSrcA;
                    srcB   <= issueSrcB;
                end
            endcase
        end else if (valid && !finish) begin
            acc <= acc + partial;
        end

        // Negating the full product carries into the upper half only when the lower half is 0.
        if (finish) begin
            if (!high)
                doneResult <= acc[XLEN-1:0];
            else if (invert)
                doneResult <= ~acc[2*XLEN-1:XLEN] + XLEN'(acc[XLEN-1:0] == '0);
            else
                doneResult <= acc[2*XLEN-1:XLEN];
            doneTagDst <= tagDst;
            doneNmDst  <= nmDst;
            doneSqN    <= sqN;
            donePc     <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== src/mulResultBuffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module mulResultBuffer (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      issueValid,
    input  wire [mulPkg::SQN_W-1:0]  issueSqN,
    input  wire                      doneValid,
    input  wire [mulPkg::XLEN-1:0]   doneResult,
    input  wire [mulPkg::TAG_W-1:0]  doneTagDst,
    input  wire [mulPkg::REG_W-1:0]  doneNmDst,
    input  wire [mulPkg::SQN_W-1:0]  doneSqN,
    input  wire [mulPkg::XLEN-1:0]   donePc,
    input  wire                      wbCredit,
    input  wire                      branchTaken,
    input  wire [mulPkg::SQN_W-1:0]  branchSqN,
    output logic                     canReserve,
    output logic                     outValid,
    output logic [mulPkg::XLEN-1:0]  outResult,
    output logic [mulPkg::TAG_W-1:0] outTagDst,
    output logic [mulPkg::REG_W-1:0] outNmDst,
    output logic [mulPkg::SQN_W-1:0] outSqN,
    output logic [mulPkg::XLEN-1:0]  outPc
);
    import mulPkg::*;

    logic [XLEN-1:0]     resQ  [RB_DEPTH];
    logic [TAG_W-1:0]    tagQ  [RB_DEPTH];
    logic [REG_W-1:0]    nmQ   [RB_DEPTH];
    logic [SQN_W-1:0]    sqNQ  [RB_DEPTH];
    logic [XLEN-1:0]     pcQ   [RB_DEPTH];
    logic [RB_DEPTH-1:0] validQ;
    logic [RB_PTR_W-1:0] head;
    logic [RB_PTR_W-1:0] tail;
    logic [CNT_W-1:0]    resvCount;                 // Issued ops that still own a slot.
    logic                infValid;                  // An op is inside the multiplier.
    logic [SQN_W-1:0]    infSqN;
    logic [CREDIT_W-1:0] credits;

    logic [RB_DEPTH-1:0] kill;
    logic [CNT_W-1:0]    killCount;
    logic [CNT_W-1:0]    occupied;
    logic                issueAcc;
    logic                doneKeep;
    logic                doneIsInf;
    logic                infKill;

    assign issueAcc  = issueValid && !(branchTaken && isYounger(issueSqN, branchSqN));
    assign doneKeep  = doneValid && !(branchTaken && isYounger(doneSqN, branchSqN));
    assign doneIsInf = doneValid && infValid && (doneSqN == infSqN);
    // A flushed result on the done port gives its slot back through doneValid.
    assign infKill   = infValid && !doneIsInf && branchTaken && isYounger(infSqN, branchSqN);

    always_comb begin
        killCount = '0;
        occupied  = '0;
        for (int i = 0; i < RB_DEPTH; i++) begin
            kill[i]   = validQ[i] && branchTaken && isYounger(sqNQ[i], branchSqN);
            killCount = killCount + CNT_W'(kill[i]);
            occupied  = occupied + CNT_W'(validQ[i]);
        end
    end

    assign canReserve = ({1'b0, occupied} + {1'b0, resvCount}) < (CNT_W+1)'(RB_DEPTH);
    assign outValid   = validQ[head] && (credits != '0) && !kill[head];
    assign outResult  = resQ[head];
    assign outTagDst  = tagQ[head];
    assign outNmDst   = nmQ[head];
    assign outSqN     = sqNQ[head];
    assign outPc      = pcQ[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            validQ    <= '0;
            head      <= '0;
            tail      <= '0;
            resvCount <= '0;
            infValid  <= 1'b0;
            credits   <= '0;
        end else begin
            for (int i = 0; i < RB_DEPTH; i++) begin
                if (kill[i])
                    validQ[i] <= 1'b0;
            end
            if (outValid) begin
                validQ[head] <= 1'b0;
                head         <= head + 1'b1;
            end
            if (doneKeep)
                validQ[tail] <= 1'b1;
            tail      <= tail - RB_PTR_W'(killCount) + RB_PTR_W'(doneKeep);
            resvCount <= resvCount + CNT_W'(issueAcc) - CNT_W'(doneValid) - CNT_W'(infKill);
            if (issueAcc) begin
                infValid <= 1'b1;
                infSqN   <= issueSqN;
            end else if (doneIsInf || infKill) begin
                infValid <= 1'b0;
            end
            credits <= credits + CREDIT_W'(wbCredit) - CREDIT_W'(outValid);
        end
    end

    always_ff @(posedge clk) begin
        if (doneKeep) begin
            resQ[tail] <= doneResult;
            tagQ[tail] <= doneTagDst;
            nmQ[tail]  <= doneNmDst;
            sqNQ[tail] <= doneSqN;
            pcQ[tail]  <= donePc;
        end
    end

endmodule

`default_nettype wire

// ==== src/mulCluster.sv ====
`timescale 1ns/1ns
`default_nettype none

module mulCluster (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         inValid,
    input  wire mulPkg::MulOp           inOp,
    input  wire [mulPkg::XLEN-1:0]      inSrcA,
    input  wire [mulPkg::XLEN-1:0]      inSrcB,
    input  wire [mulPkg::TAG_W-1:0]     inTagDst,
    input  wire [mulPkg::REG_W-1:0]     inNmDst,
    input  wire [mulPkg::SQN_W-1:0]     inSqN,
    input  wire [mulPkg::XLEN-1:0]      inPc,
    output logic [mulPkg::CREDIT_W-1:0] creditReturn,
    input  wire                         branchTaken,
    input  wire [mulPkg::SQN_W-1:0]     branchSqN,
    input  wire                         wbCredit,
    output logic                        outValid,
    output logic [mulPkg::XLEN-1:0]     outResult,
    output logic [mulPkg::TAG_W-1:0]    outTagDst,
    output logic [mulPkg::REG_W-1:0]    outNmDst,
    output logic [mulPkg::SQN_W-1:0]    outSqN,
    output logic [mulPkg::XLEN-1:0]     outPc
);
    import mulPkg::*;

    // ************************************************************************
    // Queue to multiplier
    // ************************************************************************

    logic             issueValid;
    MulOp             issueOp;
    logic [XLEN-1:0]  issueSrcA;
    logic [XLEN-1:0]  issueSrcB;
    logic [TAG_W-1:0] issueTagDst;
    logic [REG_W-1:0] issueNmDst;
    logic [SQN_W-1:0] issueSqN;
    logic [XLEN-1:0]  issuePc;
    logic             busy;
    logic             canReserve;

    // ************************************************************************
    // Multiplier to result buffer
    // ************************************************************************

    logic             doneValid;
    logic [XLEN-1:0]  doneResult;
    logic [TAG_W-1:0] doneTagDst;
    logic [REG_W-1:0] doneNmDst;
    logic [SQN_W-1:0] doneSqN;
    logic [XLEN-1:0]  donePc;

    mulIssueQueue issueQueue (
        .clk(clk), .rst(rst),
        .inValid(inValid), .inOp(inOp), .inSrcA(inSrcA), .inSrcB(inSrcB),
        .inTagDst(inTagDst), .inNmDst(inNmDst), .inSqN(inSqN), .inPc(inPc),
        .busy(busy), .canReserve(canReserve),
        .branchTaken(branchTaken), .branchSqN(branchSqN),
        .creditReturn(creditReturn),
        .issueValid(issueValid), .issueOp(issueOp),
        .issueSrcA(issueSrcA), .issueSrcB(issueSrcB),
        .issueTagDst(issueTagDst), .issueNmDst(issueNmDst),
        .issueSqN(issueSqN), .issuePc(issuePc)
    );

    multiplySmall #(.NUM_STAGES(MUL_STAGES)) multiplier (
        .clk(clk), .rst(rst),
        .issueValid(issueValid), .issueOp(issueOp),
        .issueSrcA(issueSrcA), .issueSrcB(issueSrcB),
        .issueTagDst(issueTagDst), .issueNmDst(issueNmDst),
        .issueSqN(issueSqN), .issuePc(issuePc),
        .branchTaken(branchTaken), .branchSqN(branchSqN),
        .busy(busy),
        .doneValid(doneValid), .doneResult(doneResult),
        .doneTagDst(doneTagDst), .doneNmDst(doneNmDst),
        .doneSqN(doneSqN), .donePc(donePc)
    );

    mulResultBuffer resultBuffer (
        .clk(clk), .rst(rst),
        .issueValid(issueValid), .issueSqN(issueSqN),
        .doneValid(doneValid), .doneResult(doneResult),
        .doneTagDst(doneTagDst), .doneNmDst(doneNmDst),
        .doneSqN(doneSqN), .donePc(donePc),
        .wbCredit(wbCredit),
        .branchTaken(branchTaken), .branchSqN(branchSqN),
        .canReserve(canReserve),
        .outValid(outValid), .outResult(outResult),
        .outTagDst(outTagDst), .outNmDst(outNmDst),
        .outSqN(outSqN), .outPc(outPc)
    );

endmodule

`default_nettype wire

// ==== tb/mulVectors.svh ====
`ifndef MUL_VECTORS_SVH
`define MUL_VECTORS_SVH

// Columns are opcode, srcA, srcB, branch after the row, expected result.
// A set branch flag flushes every micro-op younger than that row.

typedef struct packed {
    MulOp            op;
    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] srcB;
    logic            branch;
    logic [XLEN-1:0] expected;
} VecRow;

localparam int NUM_ROWS = 20;

VecRow vectors [NUM_ROWS] = '{
    '{MUL_MUL,   32'h0000_0003, 32'h0000_0005, 1'b0, 32'h0000_000F},
    '{MUL_MUL,   32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0, 32'h0000_0001},
    '{MUL_MULH,  32'h8000_0000, 32'hFFFF_FFFF, 1'b0, 32'h0000_0000},
    '{MUL_MUL,   32'h8000_0000, 32'hFFFF_FFFF, 1'b1, 32'h8000_0000},
    '{MUL_MULU,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0, 32'hFFFF_FFFE},
    '{MUL_MULSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0, 32'hFFFF_FFFF},
    '{MUL_MULH,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0, 32'h0000_0000},
    '{MUL_MULSU, 32'h8000_0000, 32'h0000_0002, 1'b0, 32'hFFFF_FFFF},
    '{MUL_MULH,  32'h8000_0000, 32'h8000_0000, 1'b0, 32'h4000_0000},
    '{MUL_MULU,  32'h8000_0000, 32'h0000_0004, 1'b0, 32'h0000_0002},
    '{MUL_MULH,  32'h0000_0007, 32'hFFFF_FFFD, 1'b1, 32'hFFFF_FFFF},
    '{MUL_MUL,   32'h0000_0007, 32'hFFFF_FFFD, 1'b0, 32'hFFFF_FFEB},
    '{MUL_MULSU, 32'hFFFF_FFFE, 32'h8000_0000, 1'b0, 32'hFFFF_FFFF},
    '{MUL_MULU,  32'h1234_5678, 32'h0001_0000, 1'b0, 32'h0000_1234},
    '{MUL_MUL,   32'h1234_5678, 32'h0001_0000, 1'b0, 32'h5678_0000},
    '{MUL_MULH,  32'h7FFF_FFFF, 32'h7FFF_FFFF, 1'b0, 32'h3FFF_FFFF},
    '{MUL_MULSU, 32'h0000_0003, 32'hFFFF_FFFF, 1'b1, 32'h0000_0002},
    '{MUL_MULH,  32'hFFFF_0000, 32'h0001_0000, 1'b0, 32'hFFFF_FFFF},
    '{MUL_MUL,   32'hDEAD_BEEF, 32'h0000_0000, 1'b0, 32'h0000_0000},
    '{MUL_MULU,  32'h0000_0000, 32'hFFFF_FFFF, 1'b0, 32'h0000_0000}
};

`endif

// ==== tb/mulClusterTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mulClusterTb;
    import mulPkg::*;

    `include "mulVectors.svh"

    localparam int NUM_RANDOM     = 24;
    localparam int TIMEOUT_CYCLES = (NUM_ROWS + NUM_RANDOM) * (MUL_STAGES + 8) * 4;
    localparam int STALL_FIRST    = 150;            // Writeback grants nothing in this window.
    localparam int STALL_LAST     = 260;

    logic                clk;
    logic                rst;
    logic                inValid;
    MulOp                inOp;
    logic [XLEN-1:0]     inSrcA;
    logic [XLEN-1:0]     inSrcB;
    logic [TAG_W-1:0]    inTagDst;
    logic [REG_W-1:0]    inNmDst;
    logic [SQN_W-1:0]    inSqN;
    logic [XLEN-1:0]     inPc;
    logic [CREDIT_W-1:0] creditReturn;
    logic                branchTaken;
    logic [SQN_W-1:0]    branchSqN;
    logic                wbCredit;
    logic                outValid;
    logic [XLEN-1:0]     outResult;
    logic [TAG_W-1:0]    outTagDst;
    logic [REG_W-1:0]    outNmDst;
    logic [SQN_W-1:0]    outSqN;
    logic [XLEN-1:0]     outPc;

    int                  upCredits;                 // Credits held by dispatch.
    int                  wbCreditsHeld;             // Credits the cluster has not spent yet.
    int                  cycles;
    int                  dispatched;
    int                  firstAccept;
    bit                  latencyChecked;
    logic [63:0]         wbHold;
    logic [SQN_W-1:0]    nextSqN;

    logic [SQN_W-1:0]    expSqN    [$];
    logic [TAG_W-1:0]    expTag    [$];
    logic [REG_W-1:0]    expNm     [$];
    logic [XLEN-1:0]     expPc     [$];
    logic [XLEN-1:0]     expResult [$];

    mulCluster UUT (
        .clk(clk), .rst(rst),
        .inValid(inValid), .inOp(inOp), .inSrcA(inSrcA), .inSrcB(inSrcB),
        .inTagDst(inTagDst), .inNmDst(inNmDst), .inSqN(inSqN), .inPc(inPc),
        .creditReturn(creditReturn),
        .branchTaken(branchTaken), .branchSqN(branchSqN),
        .wbCredit(wbCredit),
        .outValid(outValid), .outResult(outResult), .outTagDst(outTagDst),
        .outNmDst(outNmDst), .outSqN(outSqN), .outPc(outPc)
    );

    always #20 clk = ~clk;

    // ************************************************************************
    // Checks
    // ************************************************************************

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic checkResult(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        if (got !== exp)
            stopWithFailure($sformatf("error at %0t ns: %s is %h, expected %h",
                                      $time, name, got, exp));
    endtask

    task automatic checkSqN(input string name, input logic [SQN_W-1:0] got,
                            input logic [SQN_W-1:0] exp);
        if (got !== exp)
            stopWithFailure($sformatf("error at %0t ns: %s is %0d, expected %0d",
                                      $time, name, got, exp));
    endtask

    task automatic checkTag(input string name, input logic [TAG_W-1:0] got,
                            input logic [TAG_W-1:0] exp);
        if (got !== exp)
            stopWithFailure($sformatf("error at %0t ns: %s is %0d, expected %0d",
                                      $time, name, got, exp));
    endtask

    task automatic checkReg(input string name, input logic [REG_W-1:0] got,
                            input logic [REG_W-1:0] exp);
        if (got !== exp)
            stopWithFailure($sformatf("error at %0t ns: %s is %0d, expected %0d",
                                      $time, name, got, exp));
    endtask

    task automatic checkCredits(input string name, input logic [CREDIT_W-1:0] got,
                                input logic [CREDIT_W-1:0] exp);
        if (got !== exp)
            stopWithFailure($sformatf("error at %0t ns: %s is %0d, expected %0d",
                                      $time, name, got, exp));
    endtask

    // ************************************************************************
    // Reference model and dispatch
    // ************************************************************************

    // RISC-V result taken from the full 64-bit product.
    function automatic logic [XLEN-1:0] refProduct(input MulOp op, input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        logic signed [2*XLEN-1:0] sa;
        logic signed [2*XLEN-1:0] sb;
        logic [2*XLEN-1:0]        ua;
        logic [2*XLEN-1:0]        ub;
        logic [2*XLEN-1:0]        prod;
        sa = {{XLEN{a[XLEN-1]}}, a};
        sb = {{XLEN{b[XLEN-1]}}, b};
        ua = {{XLEN{1'b0}}, a};
        ub = {{XLEN{1'b0}}, b};
        case (op)
            MUL_MULH:  prod = sa * sb;
            MUL_MULSU: prod = sa * $signed(ub);
            default:   prod = ua * ub;
        endcase
        return (op == MUL_MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
    endfunction

    function automatic MulOp randomOp();
        logic [1:0] code;
        code = 2'($urandom % 4);
        return MulOp'(code);
    endfunction

    // Called on a falling edge. Waits for an upstream credit first.
    task automatic dispatchOp(input MulOp op, input logic [XLEN-1:0] a,
                              input logic [XLEN-1:0] b, input logic [XLEN-1:0] exp,
                              input bit onPath);
        while (upCredits == 0)
            @(negedge clk);
        inValid  = 1'b1;
        inOp     = op;
        inSrcA   = a;
        inSrcB   = b;
        inTagDst = TAG_W'(dispatched * 3 + 1);
        inNmDst  = REG_W'(dispatched);
        inSqN    = nextSqN;
        inPc     = 32'h0000_1000 + XLEN'(dispatched * 4);
        if (onPath) begin
            expSqN.push_back(inSqN);
            expTag.push_back(inTagDst);
            expNm.push_back(inNmDst);
            expPc.push_back(inPc);
            expResult.push_back(exp);
        end
        if (dispatched == 0)
            firstAccept = cycles + 1;               // The coming rising edge.
        upCredits--;
        dispatched++;
        nextSqN++;
        @(negedge clk);
        inValid = 1'b0;
    endtask

    // Sends up to two wrong-path micro-ops, then a branch that must kill them.
    task automatic flushYounger(input logic [SQN_W-1:0] keepSqN);
        for (int k = 0; k < 2; k++) begin
            if (upCredits > 0)
                dispatchOp(randomOp(), $urandom, $urandom, '0, 1'b0);
        end
        branchTaken = 1'b1;
        branchSqN   = keepSqN;
        @(negedge clk);
        branchTaken = 1'b0;
    endtask

    always @(negedge clk) begin
        if (rst)
            wbCredit = 1'b0;
        else
            wbCredit = (wbCreditsHeld < RB_DEPTH) && !wbHold[cycles % 64]
                       && !(cycles >= STALL_FIRST && cycles <= STALL_LAST);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
            stopWithFailure($sformatf("Run did not finish within %0d cycles.", TIMEOUT_CYCLES));
        if (!rst) begin
            upCredits += int'(creditReturn);
            if (upCredits > IQ_DEPTH)
                stopWithFailure("Cluster returned more upstream credits than queue entries.");
            if (outValid) begin
                if (wbCreditsHeld == 0)
                    stopWithFailure("Result was sent without a writeback credit.");
                if (expSqN.size() == 0)
                    stopWithFailure($sformatf("Result with sqN %0d arrived with none expected.",
                                              outSqN));
                checkSqN("outSqN", outSqN, expSqN.pop_front());
                checkTag("outTagDst", outTagDst, expTag.pop_front());
                checkReg("outNmDst", outNmDst, expNm.pop_front());
                checkResult("outPc", outPc, expPc.pop_front());
                checkResult("outResult", outResult, expResult.pop_front());
                // outValid rose on the edge before this one.
                if (!latencyChecked && cycles - 1 - firstAccept < MUL_STAGES + 3)
                    stopWithFailure("First result arrived sooner than the multiplier allows.");
                latencyChecked = 1'b1;
            end
            wbCreditsHeld += int'(wbCredit) - int'(outValid);
        end
    end

    initial begin
        MulOp            op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        void'($urandom(33650));
        wbHold         = {$urandom, $urandom};
        clk            = 1'b0;
        rst            = 1'b1;
        inValid        = 1'b0;
        inOp           = MUL_MUL;
        inSrcA         = '0;
        inSrcB         = '0;
        inTagDst       = '0;
        inNmDst        = '0;
        inSqN          = '0;
        inPc           = '0;
        branchTaken    = 1'b0;
        branchSqN      = '0;
        wbCredit       = 1'b0;
        upCredits      = IQ_DEPTH;
        wbCreditsHeld  = 0;
        cycles         = 0;
        dispatched     = 0;
        firstAccept    = 0;
        latencyChecked = 1'b0;
        nextSqN        = 7'd120;                    // Wraps early in the run.
        repeat (8) @(negedge clk);
        checkCredits("creditReturn", creditReturn, '0);
        if (outValid)
            stopWithFailure("outValid was high at the end of reset.");
        rst = 1'b0;

        for (int i = 0; i < NUM_ROWS; i++) begin
            dispatchOp(vectors[i].op, vectors[i].srcA, vectors[i].srcB,
                       vectors[i].expected, 1'b1);
            if (vectors[i].branch)
                flushYounger(nextSqN - 1'b1);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            op = randomOp();
            a  = $urandom;
            b  = $urandom;
            dispatchOp(op, a, b, refProduct(op, a, b), 1'b1);
        end

        while (expSqN.size() != 0)
            @(negedge clk);
        checkCredits("upstream credits", CREDIT_W'(upCredits), CREDIT_W'(IQ_DEPTH));
        repeat (MUL_STAGES + 8) @(negedge clk);    // A stray result would show up here.

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
src/mulPkg.sv
src/mulIssueQueue.sv
src/multiplySmall.sv
src/mulResultBuffer.sv
src/mulCluster.sv
tb/mulClusterTb.sv
+incdir+tb

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = mulClusterTb
FILELIST  = list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
